/* compile.f */
+incdir+hw
hw/divOpPkg.sv
hw/divCtrlPkg.sv
hw/divStep.sv
hw/divLoad.sv
hw/divSequencer.sv
hw/divResult.sv
hw/intDiv.sv
verification/intDivTb.sv

/* hw/divCtrlPkg.sv */
// Sequencer state enum for the divider control path
package divCtrlPkg;

  // IDLE waits for a new request with ack low
  // BUSY runs the recurrence, one group of quotient bits per cycle
  // DONE shows the result with ack high until the requester drops req
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    BUSY = 2'b01,
    DONE = 2'b10
  } seqStateT;

  // The fourth encoding is never entered
  // The sequencer falls back to IDLE from it

endpackage

/* hw/divLoad.sv */
// Operand capture, sign handling, dividend normalization and working registers
`timescale 1ns/1ns
`include "intDiv_settings.svh"

module divLoad (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  logic                     iterate,
  input  divOpPkg::divOpT          op,
  input  logic [`DIV_WIDTH-1:0]    dividend,
  input  logic [`DIV_WIDTH-1:0]    divisor,
  input  logic [`DIV_WIDTH-1:0]    nextRem,
  input  logic [`DIV_WIDTH-1:0]    nextQuo,
  input  logic [`DIV_WIDTH-1:0]    nextShift,
  output logic [`DIV_WIDTH-1:0]    workRem,
  output logic [`DIV_WIDTH-1:0]    workQuo,
  output logic [`DIV_WIDTH-1:0]    workShift,
  output logic [`DIV_WIDTH-1:0]    absDivisor,
  output logic [`DIV_CNT_LEN-1:0]  duration,
  output logic                     special,
  output divOpPkg::divOpT          opHeld,
  output logic                     negQuo,
  output logic                     negRem,
  output logic [`DIV_WIDTH-1:0]    dividendHeld
);
  import divOpPkg::*;

  logic                      dividendNeg;
  logic                      divisorNeg;
  logic [`DIV_WIDTH-1:0]     absDividendIn;
  logic [`DIV_WIDTH-1:0]     absDivisorIn;
  logic [`DIV_SHIFT_LEN-1:0] leadZeros;
  logic [`DIV_CNT_LEN-1:0]   skipGroups;
  logic [`DIV_SHIFT_LEN-1:0] normShift;
  logic                      divideByZero;
  logic                      signedOverflow;

  ////////////////////////////////////////
  // Request side, combinational
  ////////////////////////////////////////

  // Signs only count for DIV and REM
  assign dividendNeg   = isSignedOp(op) && dividend[`DIV_WIDTH-1];
  assign divisorNeg    = isSignedOp(op) && divisor[`DIV_WIDTH-1];
  assign absDividendIn = dividendNeg ? -dividend : dividend;
  assign absDivisorIn  = divisorNeg ? -divisor : divisor;

  // Leading zeros of the magnitude, the highest set bit wins
  // A zero dividend counts as DIV_WIDTH leading zeros
  always_comb begin
    leadZeros = `DIV_SHIFT_LEN'(`DIV_WIDTH);
    for (int i = 0; i < `DIV_WIDTH; i++) begin
      if (absDividendIn[i]) leadZeros = `DIV_SHIFT_LEN'(`DIV_WIDTH - 1 - i);
    end
  end

  // Whole groups of zeros are skipped, so the shift is rounded down to a group
  assign skipGroups = `DIV_CNT_LEN'(leadZeros / `DIV_COPIES);
  assign normShift  = `DIV_SHIFT_LEN'(skipGroups * `DIV_COPIES);
  assign duration   = `DIV_CNT_LEN'(`DIV_WIDTH / `DIV_COPIES) - skipGroups;

  // Divide by zero, or the most negative value divided by minus one
  assign divideByZero   = (divisor == '0);
  assign signedOverflow = isSignedOp(op) && (dividend == {1'b1, {(`DIV_WIDTH-1){1'b0}}})
                          && (divisor == {`DIV_WIDTH{1'b1}});
  assign special        = divideByZero || signedOverflow;

  ////////////////////////////////////////
  // Held state
  ////////////////////////////////////////

  // Op and sign flags for the result stage
  always_ff @(posedge clk) begin
    if (reset) begin
      opHeld <= DIVU;
      negQuo <= 1'b0;
      negRem <= 1'b0;
    end else if (start) begin
      opHeld <= op;
      negQuo <= dividendNeg ^ divisorNeg;
      negRem <= dividendNeg;
    end
  end

  // Working registers start clear with the normalized dividend in the shift register
  // Each iterate takes the outputs of the last step cell
  always_ff @(posedge clk) begin
    if (start) begin
      workRem      <= '0;
      workQuo      <= '0;
      workShift    <= absDividendIn << normShift;
      absDivisor   <= absDivisorIn;
      dividendHeld <= dividend;
    end else if (iterate) begin
      workRem   <= nextRem;
      workQuo   <= nextQuo;
      workShift <= nextShift;
    end
  end

endmodule

/* hw/divOpPkg.sv */
// Divide opcode enum with its signed and remainder decode functions
package divOpPkg;

  // Encoding matches the low two bits of funct3 in the M extension
  typedef enum logic [1:0] {
    DIV  = 2'b00,
    DIVU = 2'b01,
    REM  = 2'b10,
    REMU = 2'b11
  } divOpT;

  // DIV and REM read both operands as two's complement
  function automatic logic isSignedOp(input divOpT op);
    return (op == DIV) || (op == REM);
  endfunction

  // REM and REMU return the remainder rather than the quotient
  function automatic logic isRemOp(input divOpT op);
    return (op == REM) || (op == REMU);
  endfunction

endpackage

/* hw/divResult.sv */
// Result stage applying early shift, sign fixes, op select and special results
`timescale 1ns/1ns
`include "intDiv_settings.svh"

module divResult (
  input  logic [`DIV_WIDTH-1:0]     workRem,
  input  logic [`DIV_WIDTH-1:0]     workQuo,
  input  logic [`DIV_SHIFT_LEN-1:0] earlyShift,
  input  divOpPkg::divOpT           opHeld,
  input  logic                      negQuo,
  input  logic                      negRem,
  input  logic                      special,
  input  logic [`DIV_WIDTH-1:0]     dividendHeld,
  input  logic [`DIV_WIDTH-1:0]     absDivisor,
  output logic [`DIV_WIDTH-1:0]     result
);
  import divOpPkg::*;

  logic [`DIV_WIDTH-1:0] quoFull;
  logic [`DIV_WIDTH-1:0] quoSigned;
  logic [`DIV_WIDTH-1:0] remSigned;
  logic                  divideByZero;

  ////////////////////////////////////////
  // Magnitude to signed result
  ////////////////////////////////////////

  // Steps skipped by early termination would have shifted in zeros
  assign quoFull = workQuo << earlyShift;

  // Quotient is negative when exactly one operand was negative
  assign quoSigned = negQuo ? -quoFull : quoFull;

  // Remainder follows the sign of the dividend
  assign remSigned = negRem ? -workRem : workRem;

  // The held magnitude is zero only for a zero divisor
  // Any other special case is the signed overflow
  assign divideByZero = (absDivisor == '0);

  ////////////////////////////////////////
  // Output select
  ////////////////////////////////////////

  always_comb begin
    if (special && divideByZero) begin
      // Quotient is all ones and the remainder is the dividend
      if (isRemOp(opHeld)) begin
        result = dividendHeld;
      end else begin
        result = {`DIV_WIDTH{1'b1}};
      end
    end else if (special) begin
      // Overflow returns the dividend as quotient with no remainder
      if (isRemOp(opHeld)) begin
        result = '0;
      end else begin
        result = dividendHeld;
      end
    end else begin
      result = isRemOp(opHeld) ? remSigned : quoSigned;
    end
  end

endmodule

/* hw/divSequencer.sv */
// Divider control FSM with step counter, early termination and four-phase ack
`timescale 1ns/1ns
`include "intDiv_settings.svh"

module divSequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req,
  input  logic [`DIV_CNT_LEN-1:0]   duration,
  input  logic                      special,
  input  logic [`DIV_WIDTH-1:0]     workRem,
  input  logic [`DIV_WIDTH-1:0]     workShift,
  output logic                      start,
  output logic                      iterate,
  output logic                      ack,
  output logic [`DIV_SHIFT_LEN-1:0] earlyShift
);
  import divCtrlPkg::*;

  seqStateT                state;
  logic [`DIV_CNT_LEN-1:0] stepCount;
  logic                    exactDone;

  ////////////////////////////////////////
  // Early termination
  ////////////////////////////////////////

  // With a zero remainder and only zeros left to shift in,
  // every remaining step yields a zero quotient bit
  assign exactDone = (workRem == '0) && (workShift == '0);

  // The skipped steps become a left shift of the quotient
  // After a full run the counter is zero and so is the shift
  assign earlyShift = `DIV_SHIFT_LEN'(stepCount * `DIV_COPIES);

  ////////////////////////////////////////
  // Handshake and step pulses
  ////////////////////////////////////////

  // A request is taken only from IDLE with ack low
  assign start = req && !ack && (state == IDLE);

  // Ack stays high for as long as DONE is held
  assign ack = (state == DONE);

  // No step is taken in the cycle that detects an exact result
  assign iterate = (state == BUSY) && !exactDone;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      stepCount <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            stepCount <= duration;
            // Special cases have a fixed answer and skip the recurrence
            state     <= special ? DONE : BUSY;
          end
        end
        BUSY: begin
          if (exactDone) begin
            state <= DONE;
          end else begin
            stepCount <= stepCount - 1'b1;
            // The last group of quotient bits is resolved in this cycle
            if (stepCount <= 1) state <= DONE;
          end
        end
        DONE: begin
          // Back-pressure holds the result until req falls
          if (!req) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* hw/divStep.sv */
// One restoring radix-2 divide step cell
`timescale 1ns/1ns
`include "intDiv_settings.svh"

module divStep (
  input  logic [`DIV_WIDTH-1:0] remIn,
  input  logic [`DIV_WIDTH-1:0] quoIn,
  input  logic [`DIV_WIDTH-1:0] shiftIn,
  input  logic [`DIV_WIDTH-1:0] absDivisor,
  output logic [`DIV_WIDTH-1:0] remOut,
  output logic [`DIV_WIDTH-1:0] quoOut,
  output logic [`DIV_WIDTH-1:0] shiftOut
);

  logic [`DIV_WIDTH:0]   trial;
  logic [`DIV_WIDTH+1:0] diff;
  logic                  quoBit;

  // Next dividend bit enters the partial remainder from the bottom
  // The remainder is below the divisor, so one extra bit is enough
  assign trial = {remIn, shiftIn[`DIV_WIDTH-1]};

  // Trial subtraction with a sign bit on top
  assign diff = {1'b0, trial} - {2'b00, absDivisor};

  // A non-negative difference means the divisor fits
  assign quoBit = ~diff[`DIV_WIDTH+1];

  // Restore the old value when the divisor did not fit
  // In both cases the kept value is below the divisor and fits the width
  assign remOut = quoBit ? diff[`DIV_WIDTH-1:0] : trial[`DIV_WIDTH-1:0];

  // Quotient bits arrive most significant first
  assign quoOut = {quoIn[`DIV_WIDTH-2:0], quoBit};

  // Move the next dividend bit to the top
  assign shiftOut = {shiftIn[`DIV_WIDTH-2:0], 1'b0};

endmodule

/* hw/intDiv.sv */
// Integer divide unit top level with load stage, step chain, sequencer and result stage
`timescale 1ns/1ns
`include "intDiv_settings.svh"

module intDiv (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  divOpPkg::divOpT       op,
  input  logic [`DIV_WIDTH-1:0] dividend,
  input  logic [`DIV_WIDTH-1:0] divisor,
  output logic                  ack,
  output logic [`DIV_WIDTH-1:0] result
);
  import divOpPkg::*;

  logic                      start;
  logic                      iterate;
  logic                      special;
  logic                      negQuo;
  logic                      negRem;
  divOpT                     opHeld;
  logic [`DIV_CNT_LEN-1:0]   duration;
  logic [`DIV_SHIFT_LEN-1:0] earlyShift;
  logic [`DIV_WIDTH-1:0]     workRem;
  logic [`DIV_WIDTH-1:0]     workQuo;
  logic [`DIV_WIDTH-1:0]     workShift;
  logic [`DIV_WIDTH-1:0]     absDivisor;
  logic [`DIV_WIDTH-1:0]     dividendHeld;

  // Link i feeds step cell i, the last link goes back to the working registers
  logic [`DIV_COPIES:0][`DIV_WIDTH-1:0] chainRem;
  logic [`DIV_COPIES:0][`DIV_WIDTH-1:0] chainQuo;
  logic [`DIV_COPIES:0][`DIV_WIDTH-1:0] chainShift;

  assign chainRem[0]   = workRem;
  assign chainQuo[0]   = workQuo;
  assign chainShift[0] = workShift;

  divLoad uLoad (
    .clk(clk), .reset(reset), .start(start), .iterate(iterate), .op(op),
    .dividend(dividend), .divisor(divisor),
    .nextRem(chainRem[`DIV_COPIES]), .nextQuo(chainQuo[`DIV_COPIES]),
    .nextShift(chainShift[`DIV_COPIES]),
    .workRem(workRem), .workQuo(workQuo), .workShift(workShift),
    .absDivisor(absDivisor), .duration(duration), .special(special),
    .opHeld(opHeld), .negQuo(negQuo), .negRem(negRem), .dividendHeld(dividendHeld)
  );

  // One quotient bit per cell, all cells settle within one cycle
  for (genvar i = 0; i < `DIV_COPIES; i++) begin : stepCell
    divStep uStep (
      .remIn(chainRem[i]), .quoIn(chainQuo[i]), .shiftIn(chainShift[i]),
      .absDivisor(absDivisor),
      .remOut(chainRem[i+1]), .quoOut(chainQuo[i+1]), .shiftOut(chainShift[i+1])
    );
  end

  divSequencer uSequencer (
    .clk(clk), .reset(reset), .req(req), .duration(duration), .special(special),
    .workRem(workRem), .workShift(workShift),
    .start(start), .iterate(iterate), .ack(ack), .earlyShift(earlyShift)
  );

  divResult uResult (
    .workRem(workRem), .workQuo(workQuo), .earlyShift(earlyShift), .opHeld(opHeld),
    .negQuo(negQuo), .negRem(negRem), .special(special),
    .dividendHeld(dividendHeld), .absDivisor(absDivisor), .result(result)
  );

endmodule

/* hw/intDiv_settings.svh */
// Width, per-cycle step count, counter width and shift width macros for the integer divider
`ifndef INTDIV_SETTINGS_SVH
`define INTDIV_SETTINGS_SVH

// Operand and result width in bits
`define DIV_WIDTH 32

// Quotient bits resolved in each busy cycle
// This has to divide DIV_WIDTH evenly
`define DIV_COPIES 2

// Width of the duration and step counters
// It has to hold DIV_WIDTH / DIV_COPIES, which is 16 groups here
`define DIV_CNT_LEN 5

// Width of a shift amount of up to DIV_WIDTH bits
// Used for the leading zero count and the early termination shift
`define DIV_SHIFT_LEN 6

`endif

/* run.sh */
#!/bin/sh
# Builds the divider testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timing -Wno-fatal -f compile.f --top-module intDivTb \
  && ./obj_dir/VintDivTb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TEST PASSED" sim.log && echo "Simulation run passed" \
  || { echo "Simulation run failed"; exit 1; }

/* verification/divCases_input.txt */
// name opcode dividend divisor expected, all fields hex except the name
// opcode values 0 DIV, 1 DIVU, 2 REM, 3 REMU
div_pos_pos 0 00000064 00000007 0000000e
rem_pos_pos 2 00000064 00000007 00000002
div_neg_pos 0 ffffff9c 00000007 fffffff2
rem_neg_pos 2 ffffff9c 00000007 fffffffe
div_pos_neg 0 00000064 fffffff9 fffffff2
rem_pos_neg 2 00000064 fffffff9 00000002
div_neg_neg 0 ffffff9c fffffff9 0000000e
rem_neg_neg 2 ffffff9c fffffff9 fffffffe
divu_large 1 ffffff9c 00000007 24924916
remu_large 3 ffffff9c 00000007 00000002
divu_all_ones 1 ffffffff 00000003 55555555
div_rand_a 0 12345678 00000123 001003d0
rem_rand_a 2 12345678 00000123 00000108
div_rand_b 0 edcba988 00000123 ffeffc30
rem_rand_b 2 edcba988 00000123 fffffef8
divu_rand_c 1 9abcdef0 00001000 0009abcd
remu_rand_c 3 9abcdef0 00001000 00000ef0
div_by_zero 0 12345678 00000000 ffffffff
divu_by_zero 1 12345678 00000000 ffffffff
rem_by_zero 2 87654321 00000000 87654321
remu_by_zero 3 87654321 00000000 87654321
div_overflow 0 80000000 ffffffff 80000000
rem_overflow 2 80000000 ffffffff 00000000
divu_min_by_ones 1 80000000 ffffffff 00000000
remu_min_by_ones 3 80000000 ffffffff 80000000
div_exact 0 00010000 00000100 00000100
rem_exact 2 00010000 00000100 00000000
div_exact_neg 0 fffff000 00000010 ffffff00
divu_exact_pair 1 00ff00ff 000000ff 00010001
div_zero_dividend 0 00000000 00000005 00000000
rem_one_by_three 2 00000001 00000003 00000001
rem_minus_one_by_three 2 ffffffff 00000003 ffffffff
div_min_by_two 0 80000000 00000002 c0000000
divu_equal 1 deadbeef deadbeef 00000001

/* verification/intDivTb.sv */
// Self-checking testbench for the integer divide unit, driven from a case file
`timescale 1ns/1ns
`include "intDiv_settings.svh"

module intDivTb;
  import divOpPkg::*;

  localparam int ClkPeriod = 4;
  localparam int Groups = `DIV_WIDTH / `DIV_COPIES;
  // Cycle 1 is the one that presents req
  localparam int MaxLatency = Groups + 2;
  localparam int SpecialLatency = 2;
  localparam int MaxHold = 8;
  localparam string CaseFile = "verification/divCases_input.txt";

  logic                  clk;
  logic                  reset;
  logic                  req;
  divOpT                 op;
  logic [`DIV_WIDTH-1:0] dividend;
  logic [`DIV_WIDTH-1:0] divisor;
  logic                  ack;
  logic [`DIV_WIDTH-1:0] result;

  // Cases as read from the file
  string                 caseName[$];
  divOpT                 caseOp[$];
  logic [`DIV_WIDTH-1:0] caseDividend[$];
  logic [`DIV_WIDTH-1:0] caseDivisor[$];
  logic [`DIV_WIDTH-1:0] caseExpected[$];

  int caseCount;
  bit casesLoaded;
  int errorCount;
  int passCount;
  int failCount;

  intDiv u_dut (
    .clk(clk), .reset(reset), .req(req), .op(op),
    .dividend(dividend), .divisor(divisor), .ack(ack), .result(result)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // RISC-V M special cases finish without running the recurrence
  // Zero divisor for any op, or the most negative value over minus one for DIV and REM
  function automatic bit isSpecialCase(input divOpT caseOpIn,
                                       input logic [`DIV_WIDTH-1:0] a,
                                       input logic [`DIV_WIDTH-1:0] b);
    bit signedOp;
    signedOp = (caseOpIn == DIV) || (caseOpIn == REM);
    return (b == '0) ||
           (signedOp && (a == {1'b1, {(`DIV_WIDTH-1){1'b0}}}) && (b == '1));
  endfunction

  // Lines that do not hold five fields are comments and get skipped
  task automatic loadCases();
    int                    fd;
    int                    fields;
    logic [8*128-1:0]      line;
    logic [8*32-1:0]       nameVec;
    logic [31:0]           opVal;
    logic [`DIV_WIDTH-1:0] a;
    logic [`DIV_WIDTH-1:0] b;
    logic [`DIV_WIDTH-1:0] e;
    fd = $fopen(CaseFile, "r");
    if (fd == 0) begin
      $display("Could not open the case file %s", CaseFile);
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        if ($fgets(line, fd) > 0) begin
          fields = $sscanf(line, "%s %h %h %h %h", nameVec, opVal, a, b, e);
          if (fields == 5) begin
            caseName.push_back(string'(nameVec));
            caseOp.push_back(divOpT'(opVal[1:0]));
            caseDividend.push_back(a);
            caseDivisor.push_back(b);
            caseExpected.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Runs one full four-phase transaction that starts on a falling edge with ack low
  task automatic runCase(input int idx);
    int                    latency;
    int                    holdCycles;
    int                    errorsBefore;
    bit                    special;
    logic [`DIV_WIDTH-1:0] expected;
    logic [`DIV_WIDTH-1:0] held;
    errorsBefore = errorCount;
    expected     = caseExpected[idx];
    special      = isSpecialCase(caseOp[idx], caseDividend[idx], caseDivisor[idx]);
    op       = caseOp[idx];
    dividend = caseDividend[idx];
    divisor  = caseDivisor[idx];
    req      = 1'b1;
    latency  = 1;
    @(negedge clk);
    latency++;
    while (!ack) begin
      @(negedge clk);
      latency++;
    end
    if (special) begin
      assert (latency == SpecialLatency) else begin
        $display("CHECK FAILED %s ack latency: expected %0d, actual %0d",
                 caseName[idx], SpecialLatency, latency);
        errorCount++;
      end
    end else begin
      assert (latency <= MaxLatency) else begin
        $display("%s: ack took %0d cycles, more than the limit of %0d",
                 caseName[idx], latency, MaxLatency);
        errorCount++;
      end
    end
    assert (result === expected) else begin
      $display("CHECK FAILED %s: expected %h, actual %h", caseName[idx], expected, result);
      errorCount++;
    end

    // The result must not move while req stays high under back-pressure
    held       = result;
    holdCycles = $urandom % MaxHold;
    repeat (holdCycles) begin
      @(negedge clk);
      assert (ack === 1'b1) else begin
        $display("%s: ack fell while req was still high", caseName[idx]);
        errorCount++;
      end
      assert (result === held) else begin
        $display("CHECK FAILED %s held result: expected %h, actual %h",
                 caseName[idx], held, result);
        errorCount++;
      end
    end

    // Ack goes low exactly one cycle after req while the operands stay put
    req = 1'b0;
    @(negedge clk);
    assert (ack === 1'b0) else begin
      $display("%s: ack was still high one cycle after req fell", caseName[idx]);
      errorCount++;
    end
    while (ack) @(negedge clk);

    if (errorCount == errorsBefore) begin
      passCount++;
      $display("PASS %s  latency %0d  hold %0d", caseName[idx], latency, holdCycles);
    end else begin
      failCount++;
      $display("FAIL %s", caseName[idx]);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(94));
    reset       = 1'b1;
    req         = 1'b0;
    op          = DIVU;
    dividend    = '0;
    divisor     = '0;
    errorCount  = 0;
    passCount   = 0;
    failCount   = 0;
    casesLoaded = 1'b0;
    loadCases();
    caseCount   = caseName.size();
    casesLoaded = 1'b1;
    // Two rising edges see reset before it drops on the next falling edge
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    assert (ack === 1'b0) else begin
      $display("Ack was not low after reset");
      errorCount++;
    end
    if (caseCount == 0) begin
      $display("No cases were read from %s", CaseFile);
      errorCount++;
    end
    // Each case starts on the edge where the previous ack was seen low
    for (int i = 0; i < caseCount; i++) begin
      runCase(i);
    end
    $display("Cases: %0d  passed: %0d  failed: %0d  check errors: %0d",
             caseCount, passCount, failCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // The watchdog limit grows with the case count and leaves ample room per case
  initial begin
    int limitCycles;
    wait (casesLoaded);
    limitCycles = ((caseCount > 0) ? caseCount : 1) * (Groups + 40);
    #(limitCycles * ClkPeriod);
    $display("Timeout, the run did not finish within %0d cycles", limitCycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule
